// File: design/exu_pkg.sv
// Execute stage definitions
package exu_pkg;

  localparam int XLEN = 64;

  typedef logic [XLEN-1:0] xword_t;

  // alu operation codes
  typedef logic [4:0] alu_op_t;
  localparam alu_op_t ALU_ADD  = 5'b00000;
  localparam alu_op_t ALU_SUB  = 5'b00001;
  localparam alu_op_t ALU_SLT  = 5'b00010;
  localparam alu_op_t ALU_SLTU = 5'b00011;
  localparam alu_op_t ALU_XOR  = 5'b00100;
  localparam alu_op_t ALU_AND  = 5'b00101;
  localparam alu_op_t ALU_OR   = 5'b00110;
  localparam alu_op_t ALU_SLL  = 5'b00111;
  localparam alu_op_t ALU_SRL  = 5'b01000;
  localparam alu_op_t ALU_SRA  = 5'b01001;
  localparam alu_op_t ALU_MUL  = 5'b01010;
  localparam alu_op_t ALU_DIV  = 5'b01011;
  localparam alu_op_t ALU_DIVU = 5'b01100;
  localparam alu_op_t ALU_REM  = 5'b01101;
  localparam alu_op_t ALU_REMU = 5'b01110;
  localparam alu_op_t ALU_COPY = 5'b01111;

  typedef logic [2:0] branch_t;
  localparam branch_t BR_NONE = 3'b000;
  localparam branch_t BR_JAL  = 3'b001;
  localparam branch_t BR_JALR = 3'b010;
  localparam branch_t BR_EQ   = 3'b100;
  localparam branch_t BR_NE   = 3'b101;
  localparam branch_t BR_LT   = 3'b110;
  localparam branch_t BR_GE   = 3'b111;

  // load size and signedness
  typedef logic [2:0] mem_op_t;
  localparam mem_op_t LD_B  = 3'b000;
  localparam mem_op_t LD_BU = 3'b001;
  localparam mem_op_t LD_H  = 3'b010;
  localparam mem_op_t LD_HU = 3'b011;
  localparam mem_op_t LD_W  = 3'b100;
  localparam mem_op_t LD_WU = 3'b101;
  localparam mem_op_t LD_D  = 3'b110;

  typedef logic [3:0] ex_ctr_t;
  localparam ex_ctr_t EX_CSR_WRITE = 4'b0000;
  localparam ex_ctr_t EX_EBREAK    = 4'b1110;

  typedef logic [1:0] bsrc_t;
  localparam bsrc_t SRC_B_RS2  = 2'b00;
  localparam bsrc_t SRC_B_IMM  = 2'b01;
  localparam bsrc_t SRC_B_FOUR = 2'b10;

endpackage

// File: design/exu_div_if.sv
// Divider link
`timescale 1ns/1ns

interface exu_div_if;
  import exu_pkg::*;

  logic   req;
  logic   ack;
  logic   is_signed;
  logic   is_rem;
  logic   is_word;
  xword_t dividend;
  xword_t divisor;
  xword_t result;

  // sequencer side
  modport master (
    output req, is_signed, is_rem, is_word, dividend, divisor,
    input  ack, result
  );

  modport slave (
    input  req, is_signed, is_rem, is_word, dividend, divisor,
    output ack, result
  );

endinterface

// File: design/exu_alu.sv
// Single-cycle ALU
`timescale 1ns/1ns

module exu_alu (
  input  exu_pkg::xword_t  i_rs1,
  input  exu_pkg::xword_t  i_rs2,
  input  exu_pkg::xword_t  i_imm,
  input  exu_pkg::xword_t  i_pc,
  input  logic             i_a_pc,
  input  exu_pkg::bsrc_t   i_b_src,
  input  exu_pkg::alu_op_t i_alu_op,
  input  logic             i_word,
  output exu_pkg::xword_t  o_result,
  output exu_pkg::xword_t  o_src_a,
  output exu_pkg::xword_t  o_src_b,
  output logic             o_zero,
  output logic             o_less
);
  import exu_pkg::*;

  xword_t     src1;
  xword_t     src2;
  xword_t     imm;
  xword_t     src_a;
  xword_t     src_b;
  xword_t     sub_result;
  xword_t     sra64;
  xword_t     raw;
  logic [31:0] sra32;
  logic [5:0] shamt;
  logic       cout;
  logic       overflow;
  logic       signed_less;
  logic       unsigned_less;

  // word ops see zero-extended low halves
  assign src1 = i_word ? {32'b0, i_rs1[31:0]} : i_rs1;
  assign src2 = i_word ? {32'b0, i_rs2[31:0]} : i_rs2;
  assign imm  = i_word ? {32'b0, i_imm[31:0]} : i_imm;

  assign src_a = i_a_pc ? i_pc : src1;

  always_comb begin
    case (i_b_src)
      SRC_B_IMM:  src_b = imm;
      SRC_B_FOUR: src_b = 64'd4;
      default:    src_b = src2;
    endcase
  end

  // carry out is set when a >= b unsigned
  assign {cout, sub_result} = {1'b0, src_a} + {1'b0, ~src_b} + 65'd1;
  assign overflow = (src_a[XLEN-1] ^ src_b[XLEN-1]) & (src_a[XLEN-1] ^ sub_result[XLEN-1]);
  assign signed_less   = sub_result[XLEN-1] ^ overflow;
  assign unsigned_less = ~cout;

  assign shamt = i_word ? {1'b0, src_b[4:0]} : src_b[5:0];
  assign sra32 = $signed(src_a[31:0]) >>> shamt;
  assign sra64 = $signed(src_a) >>> shamt;

  always_comb begin
    case (i_alu_op)
      ALU_ADD:  raw = src_a + src_b;
      ALU_SUB:  raw = sub_result;
      ALU_SLT:  raw = xword_t'(signed_less);
      ALU_SLTU: raw = xword_t'(unsigned_less);
      ALU_XOR:  raw = src_a ^ src_b;
      ALU_AND:  raw = src_a & src_b;
      ALU_OR:   raw = src_a | src_b;
      ALU_SLL:  raw = src_a << shamt;
      ALU_SRL:  raw = src_a >> shamt;
      ALU_SRA:  raw = i_word ? {{32{src_a[31]}}, sra32} : sra64;
      ALU_MUL:  raw = src_a * src_b;
      ALU_COPY: raw = i_imm;
      default:  raw = '0;
    endcase
  end

  assign o_result = i_word ? {{32{raw[31]}}, raw[31:0]} : raw;
  assign o_src_a  = src_a;
  assign o_src_b  = src_b;
  assign o_zero   = ~|sub_result;
  // blt/bge decode as slt, bltu/bgeu as sltu
  assign o_less   = (i_alu_op == ALU_SLTU) ? unsigned_less : signed_less;

endmodule

// File: design/exu_divider.sv
// Iterative restoring divider
`timescale 1ns/1ns

module exu_divider #(
  parameter int XLEN = exu_pkg::XLEN
) (
  input logic      i_clk,
  input logic      i_rst_n,
  exu_div_if.slave div
);

  typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} div_state_t;

  localparam int CW = $clog2(XLEN + 1);

  div_state_t      state;
  logic [CW-1:0]   count;
  logic [XLEN-1:0] a_ext;
  logic [XLEN-1:0] b_ext;
  logic [XLEN-1:0] min_val;
  logic            a_neg;
  logic            b_neg;
  logic [XLEN-1:0] quo;
  logic [XLEN-1:0] rem;
  logic [XLEN-1:0] dvs;
  logic [XLEN-1:0] dnd;
  logic            neg_q;
  logic            neg_r;
  logic            rem_sel;
  logic            word;
  logic            div_zero;
  logic            ovf;
  logic [XLEN:0]   rem_shift;
  logic [XLEN:0]   diff;
  logic [XLEN-1:0] fixed;
  logic [XLEN-1:0] result_q;

  // word ops extend the low 32 bits by signedness
  always_comb begin
    if (div.is_word) begin
      a_ext   = {{(XLEN-32){div.is_signed & div.dividend[31]}}, div.dividend[31:0]};
      b_ext   = {{(XLEN-32){div.is_signed & div.divisor[31]}}, div.divisor[31:0]};
      min_val = {{(XLEN-31){1'b1}}, {31{1'b0}}};
    end else begin
      a_ext   = div.dividend;
      b_ext   = div.divisor;
      min_val = {1'b1, {(XLEN-1){1'b0}}};
    end
  end

  assign a_neg = div.is_signed & a_ext[XLEN-1];
  assign b_neg = div.is_signed & b_ext[XLEN-1];

  assign rem_shift = {rem, quo[XLEN-1]};
  assign diff      = rem_shift - {1'b0, dvs};

  // special cases follow the RISC-V rules
  always_comb begin
    if (div_zero)
      fixed = rem_sel ? dnd : '1;
    else if (ovf)
      fixed = rem_sel ? '0 : dnd;
    else if (rem_sel)
      fixed = neg_r ? -rem : rem;
    else
      fixed = neg_q ? -quo : quo;
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state <= DIV_IDLE;
      count <= '0;
    end else begin
      case (state)
        DIV_IDLE: if (div.req) begin
          state <= DIV_RUN;
          count <= '0;
        end
        DIV_RUN: begin
          if (div_zero || ovf || count == CW'(XLEN))
            state <= DIV_DONE;
          count <= count + 1'b1;
        end
        DIV_DONE: if (!div.req) state <= DIV_IDLE;
        default: state <= DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == DIV_IDLE && div.req) begin
      quo      <= a_neg ? -a_ext : a_ext;
      dvs      <= b_neg ? -b_ext : b_ext;
      rem      <= '0;
      dnd      <= a_ext;
      neg_q    <= a_neg ^ b_neg;
      neg_r    <= a_neg;
      rem_sel  <= div.is_rem;
      word     <= div.is_word;
      div_zero <= ~|b_ext;
      ovf      <= div.is_signed & (a_ext == min_val) & (&b_ext);
    end else if (state == DIV_RUN) begin
      if (div_zero || ovf || count == CW'(XLEN)) begin
        result_q <= word ? {{(XLEN-32){fixed[31]}}, fixed[31:0]} : fixed;
      end else if (!diff[XLEN]) begin
        rem <= diff[XLEN-1:0];
        quo <= {quo[XLEN-2:0], 1'b1};
      end else begin
        rem <= rem_shift[XLEN-1:0];
        quo <= {quo[XLEN-2:0], 1'b0};
      end
    end
  end

  assign div.ack    = (state == DIV_DONE);
  assign div.result = result_q;

endmodule

// File: design/exu_branch_wb.sv
// Next pc and write-back select
`timescale 1ns/1ns

module exu_branch_wb (
  input  exu_pkg::xword_t   i_pc,
  input  exu_pkg::xword_t   i_rs1,
  input  exu_pkg::xword_t   i_rs2,
  input  exu_pkg::xword_t   i_imm,
  input  exu_pkg::xword_t   i_rdata,
  input  exu_pkg::xword_t   i_exe_result,
  input  exu_pkg::xword_t   i_src_a,
  input  exu_pkg::branch_t  i_branch,
  input  logic              i_zero,
  input  logic              i_less,
  input  logic              i_mem_to_reg,
  input  logic              i_sel_csr,
  input  exu_pkg::mem_op_t  i_mem_op,
  input  exu_pkg::ex_ctr_t  i_ex_ctr,
  output exu_pkg::xword_t   o_next_pc,
  output exu_pkg::xword_t   o_gpr_wdata,
  output exu_pkg::xword_t   o_csr_wdata,
  output logic              o_halt
);
  import exu_pkg::*;

  logic   taken;
  logic   base_rs1;
  xword_t ld_data;

  always_comb begin
    taken    = 1'b0;
    base_rs1 = 1'b0;
    case (i_branch)
      BR_NONE: taken = 1'b0;
      BR_JAL:  taken = 1'b1;
      BR_JALR: begin
        taken    = 1'b1;
        base_rs1 = 1'b1;
      end
      BR_EQ:   taken = i_zero;
      BR_NE:   taken = ~i_zero;
      BR_LT:   taken = i_less;
      BR_GE:   taken = ~i_less;
      default: taken = 1'b0;
    endcase
  end

  assign o_next_pc = (base_rs1 ? i_rs1 : i_pc) + (taken ? i_imm : 64'd4);

  // load data extension
  always_comb begin
    case (i_mem_op)
      LD_B:    ld_data = {{56{i_rdata[7]}}, i_rdata[7:0]};
      LD_BU:   ld_data = {56'b0, i_rdata[7:0]};
      LD_H:    ld_data = {{48{i_rdata[15]}}, i_rdata[15:0]};
      LD_HU:   ld_data = {48'b0, i_rdata[15:0]};
      LD_W:    ld_data = {{32{i_rdata[31]}}, i_rdata[31:0]};
      LD_WU:   ld_data = {32'b0, i_rdata[31:0]};
      LD_D:    ld_data = i_rdata;
      default: ld_data = i_rdata;
    endcase
  end

  assign o_gpr_wdata = i_mem_to_reg ? ld_data : (i_sel_csr ? i_rs2 : i_exe_result);
  assign o_csr_wdata = (i_ex_ctr == EX_CSR_WRITE) ? i_src_a : '0;
  assign o_halt      = (i_ex_ctr == EX_EBREAK);

endmodule

// File: design/exu_top.sv
// Execute stage top
`timescale 1ns/1ns

module exu_top #(
  parameter int XLEN = exu_pkg::XLEN
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_req,
  input  exu_pkg::xword_t   i_rs1,
  input  exu_pkg::xword_t   i_rs2,
  input  exu_pkg::xword_t   i_imm,
  input  exu_pkg::xword_t   i_pc,
  input  exu_pkg::xword_t   i_rdata,
  input  logic              i_a_pc,
  input  exu_pkg::bsrc_t    i_b_src,
  input  exu_pkg::alu_op_t  i_alu_op,
  input  logic              i_word,
  input  exu_pkg::branch_t  i_branch,
  input  exu_pkg::mem_op_t  i_mem_op,
  input  logic              i_mem_to_reg,
  input  exu_pkg::ex_ctr_t  i_ex_ctr,
  input  logic              i_sel_csr,
  output logic              o_ack,
  output exu_pkg::xword_t   o_alu_result,
  output exu_pkg::xword_t   o_next_pc,
  output exu_pkg::xword_t   o_gpr_wdata,
  output exu_pkg::xword_t   o_csr_wdata,
  output logic              o_halt
);
  import exu_pkg::*;

  typedef enum logic [1:0] {SEQ_IDLE, SEQ_DIV, SEQ_ACK} seq_state_t;

  seq_state_t state;
  logic       div_req;
  logic       is_div;
  logic       capture;
  logic       zero;
  logic       less;
  logic       halt;
  xword_t     alu_result;
  xword_t     src_a;
  xword_t     src_b;
  xword_t     exe_result;
  xword_t     next_pc;
  xword_t     gpr_wdata;
  xword_t     csr_wdata;

  exu_div_if div_if ();

  assign is_div = i_alu_op inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};

  assign div_if.req       = div_req;
  assign div_if.is_signed = (i_alu_op == ALU_DIV) || (i_alu_op == ALU_REM);
  assign div_if.is_rem    = (i_alu_op == ALU_REM) || (i_alu_op == ALU_REMU);
  assign div_if.is_word   = i_word;
  assign div_if.dividend  = src_a;
  assign div_if.divisor   = src_b;

  assign exe_result = is_div ? div_if.result : alu_result;

  exu_alu alu_i (
    .i_rs1(i_rs1), .i_rs2(i_rs2), .i_imm(i_imm), .i_pc(i_pc),
    .i_a_pc(i_a_pc), .i_b_src(i_b_src), .i_alu_op(i_alu_op), .i_word(i_word),
    .o_result(alu_result), .o_src_a(src_a), .o_src_b(src_b),
    .o_zero(zero), .o_less(less)
  );

  exu_divider #(.XLEN(XLEN)) divider_i (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .div(div_if)
  );

  exu_branch_wb branch_wb_i (
    .i_pc(i_pc), .i_rs1(i_rs1), .i_rs2(i_rs2), .i_imm(i_imm), .i_rdata(i_rdata),
    .i_exe_result(exe_result), .i_src_a(src_a), .i_branch(i_branch),
    .i_zero(zero), .i_less(less), .i_mem_to_reg(i_mem_to_reg), .i_sel_csr(i_sel_csr),
    .i_mem_op(i_mem_op), .i_ex_ctr(i_ex_ctr),
    .o_next_pc(next_pc), .o_gpr_wdata(gpr_wdata), .o_csr_wdata(csr_wdata), .o_halt(halt)
  );

  // results are taken once the op completes
  assign capture = (state == SEQ_IDLE && i_req && !is_div) ||
                   (state == SEQ_DIV && div_if.ack);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state   <= SEQ_IDLE;
      div_req <= 1'b0;
      o_ack   <= 1'b0;
    end else begin
      case (state)
        SEQ_IDLE: if (i_req) begin
          if (!is_div) begin
            o_ack <= 1'b1;
            state <= SEQ_ACK;
          end else if (!div_if.ack) begin
            // wait for the divider to finish its previous handshake
            div_req <= 1'b1;
            state   <= SEQ_DIV;
          end
        end
        SEQ_DIV: if (div_if.ack) begin
          o_ack <= 1'b1;
          state <= SEQ_ACK;
        end
        SEQ_ACK: if (!i_req) begin
          o_ack   <= 1'b0;
          div_req <= 1'b0;
          state   <= SEQ_IDLE;
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_alu_result <= '0;
      o_next_pc    <= '0;
      o_gpr_wdata  <= '0;
      o_csr_wdata  <= '0;
      o_halt       <= 1'b0;
    end else if (capture) begin
      o_alu_result <= exe_result;
      o_next_pc    <= next_pc;
      o_gpr_wdata  <= gpr_wdata;
      o_csr_wdata  <= csr_wdata;
      o_halt       <= halt;
    end
  end

endmodule

// File: tests/exu_properties.sv
// Handshake properties
`timescale 1ns/1ns

module exu_properties (
  input logic            i_clk,
  input logic            i_rst_n,
  input logic            i_req,
  input logic            i_ack,
  input exu_pkg::xword_t i_alu_result,
  input exu_pkg::xword_t i_next_pc,
  input exu_pkg::xword_t i_gpr_wdata,
  input exu_pkg::xword_t i_csr_wdata,
  input logic            i_halt
);

  int fail_count = 0;

  assert property (@(posedge i_clk) !i_rst_n |-> !i_ack)
    else begin
      fail_count++;
      $error("ack high while reset is asserted");
    end

  // ack only answers a request seen on the previous edge
  assert property (@(posedge i_clk) disable iff (!i_rst_n) $rose(i_ack) |-> $past(i_req))
    else begin
      fail_count++;
      $error("ack rose without a pending request");
    end

  assert property (@(posedge i_clk) disable iff (!i_rst_n) $fell(i_ack) |-> !$past(i_req))
    else begin
      fail_count++;
      $error("ack fell while the request was still high");
    end

  // results frozen for the whole acknowledge phase
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_ack && $past(i_ack)) |->
      $stable({i_alu_result, i_next_pc, i_gpr_wdata, i_csr_wdata, i_halt}))
    else begin
      fail_count++;
      $error("results changed while ack was high");
    end

endmodule

// File: tests/exu_tb.sv
// Execute stage testbench
`timescale 1ns/1ns

module exu_tb;
  import exu_pkg::*;

  localparam int ACK_TIMEOUT = 200;

  logic    i_clk;
  logic    i_rst_n;
  logic    i_req;
  xword_t  i_rs1, i_rs2, i_imm, i_pc, i_rdata;
  logic    i_a_pc;
  bsrc_t   i_b_src;
  alu_op_t i_alu_op;
  logic    i_word;
  branch_t i_branch;
  mem_op_t i_mem_op;
  logic    i_mem_to_reg;
  ex_ctr_t i_ex_ctr;
  logic    i_sel_csr;
  logic    o_ack;
  xword_t  o_alu_result, o_next_pc, o_gpr_wdata, o_csr_wdata;
  logic    o_halt;

  xword_t  exp_alu, exp_npc, exp_gpr, exp_csr;
  logic    exp_halt;
  integer  seed = 32'hffe1_c424;
  int      checks;
  int      errors;
  int      test_errors;

  exu_top #(.XLEN(XLEN)) exu_top_i (.*);

  bind exu_top exu_properties props_i (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_req(i_req), .i_ack(o_ack),
    .i_alu_result(o_alu_result), .i_next_pc(o_next_pc), .i_gpr_wdata(o_gpr_wdata),
    .i_csr_wdata(o_csr_wdata), .i_halt(o_halt)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  function automatic xword_t rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic xword_t sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic logic is_divide(input alu_op_t op);
    return op inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
  endfunction

  function automatic xword_t alu_model(input alu_op_t op, input xword_t a, input xword_t b,
                                       input xword_t imm, input logic word);
    logic [5:0]  sh;
    logic [31:0] sra_w;
    xword_t      sra_d;
    xword_t      r;
    sh    = word ? {1'b0, b[4:0]} : b[5:0];
    sra_w = $signed(a[31:0]) >>> sh;
    sra_d = $signed(a) >>> sh;
    case (op)
      ALU_ADD:  r = a + b;
      ALU_SUB:  r = a - b;
      ALU_SLT:  r = {63'b0, $signed(a) < $signed(b)};
      ALU_SLTU: r = {63'b0, a < b};
      ALU_XOR:  r = a ^ b;
      ALU_AND:  r = a & b;
      ALU_OR:   r = a | b;
      ALU_SLL:  r = a << sh;
      ALU_SRL:  r = a >> sh;
      ALU_SRA:  r = word ? sext32(sra_w) : sra_d;
      ALU_MUL:  r = a * b;
      ALU_COPY: r = imm;
      default:  r = '0;
    endcase
    return word ? sext32(r[31:0]) : r;
  endfunction

  // RISC-V division with the zero divisor and overflow cases
  function automatic xword_t div_model(input alu_op_t op, input xword_t x, input xword_t y,
                                       input logic word);
    logic   sgn;
    xword_t a, b, q, r, minv, res;
    sgn  = (op == ALU_DIV) || (op == ALU_REM);
    a    = x;
    b    = y;
    minv = {1'b1, 63'b0};
    if (word) begin
      a    = sgn ? sext32(x[31:0]) : {32'b0, x[31:0]};
      b    = sgn ? sext32(y[31:0]) : {32'b0, y[31:0]};
      minv = sext32(32'h8000_0000);
    end
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (sgn && a == minv && b == '1) begin
      q = a;
      r = '0;
    end else if (sgn) begin
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
    res = (op == ALU_REM || op == ALU_REMU) ? r : q;
    return word ? sext32(res[31:0]) : res;
  endfunction

  task automatic predict_outputs();
    xword_t a, b, exe;
    logic   taken;
    logic   less;
    a = i_a_pc ? i_pc : (i_word ? {32'b0, i_rs1[31:0]} : i_rs1);
    case (i_b_src)
      SRC_B_IMM:  b = i_word ? {32'b0, i_imm[31:0]} : i_imm;
      SRC_B_FOUR: b = 64'd4;
      default:    b = i_word ? {32'b0, i_rs2[31:0]} : i_rs2;
    endcase
    if (is_divide(i_alu_op))
      exe = div_model(i_alu_op, a, b, i_word);
    else
      exe = alu_model(i_alu_op, a, b, i_imm, i_word);
    less = (i_alu_op == ALU_SLTU) ? (a < b) : ($signed(a) < $signed(b));
    case (i_branch)
      BR_JAL, BR_JALR: taken = 1'b1;
      BR_EQ:   taken = (a == b);
      BR_NE:   taken = (a != b);
      BR_LT:   taken = less;
      BR_GE:   taken = !less;
      default: taken = 1'b0;
    endcase
    exp_npc = ((i_branch == BR_JALR) ? i_rs1 : i_pc) + (taken ? i_imm : 64'd4);
    if (i_mem_to_reg) begin
      case (i_mem_op)
        LD_B:    exp_gpr = {{56{i_rdata[7]}}, i_rdata[7:0]};
        LD_BU:   exp_gpr = {56'b0, i_rdata[7:0]};
        LD_H:    exp_gpr = {{48{i_rdata[15]}}, i_rdata[15:0]};
        LD_HU:   exp_gpr = {48'b0, i_rdata[15:0]};
        LD_W:    exp_gpr = sext32(i_rdata[31:0]);
        LD_WU:   exp_gpr = {32'b0, i_rdata[31:0]};
        default: exp_gpr = i_rdata;
      endcase
    end else begin
      exp_gpr = i_sel_csr ? i_rs2 : exe;
    end
    exp_alu  = exe;
    exp_csr  = (i_ex_ctr == EX_CSR_WRITE) ? a : '0;
    exp_halt = (i_ex_ctr == EX_EBREAK);
  endtask

  task automatic check_value(input string name, input xword_t got, input xword_t want);
    checks++;
    assert (got === want) else begin
      errors++;
      $display("error at %0t ns: %s got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic check_outputs();
    check_value("o_alu_result", o_alu_result, exp_alu);
    check_value("o_next_pc", o_next_pc, exp_npc);
    check_value("o_gpr_wdata", o_gpr_wdata, exp_gpr);
    check_value("o_csr_wdata", o_csr_wdata, exp_csr);
    check_value("o_halt", xword_t'(o_halt), xword_t'(exp_halt));
  endtask

  task automatic abort_on_timeout(input string why);
    $display("timeout at %0t ns: %s", $time, why);
    $display("Checks failed");
    $finish;
  endtask

  task automatic set_idle_inputs();
    i_req        = 1'b0;
    i_rs1        = '0;
    i_rs2        = '0;
    i_imm        = '0;
    i_pc         = 64'h1000;
    i_rdata      = '0;
    i_a_pc       = 1'b0;
    i_b_src      = SRC_B_RS2;
    i_alu_op     = ALU_ADD;
    i_word       = 1'b0;
    i_branch     = BR_NONE;
    i_mem_op     = LD_D;
    i_mem_to_reg = 1'b0;
    i_ex_ctr     = 4'b0001;
    i_sel_csr    = 1'b0;
  endtask

  // full four-phase exchange with hold extra cycles of back-pressure
  task automatic run_request(input int hold);
    int cycles;
    predict_outputs();
    i_req  = 1'b1;
    cycles = 0;
    do begin
      @(posedge i_clk);
      #1;
      cycles++;
    end while (o_ack !== 1'b1 && cycles < ACK_TIMEOUT);
    if (o_ack !== 1'b1)
      abort_on_timeout("o_ack never rose after i_req was raised");
    if (!is_divide(i_alu_op)) begin
      checks++;
      assert (cycles == 1) else begin
        errors++;
        $display("non-divide request took %0d cycles to acknowledge, expected one", cycles);
      end
    end
    check_outputs();
    repeat (hold) begin
      @(posedge i_clk);
      #1;
      checks++;
      assert (o_ack === 1'b1) else begin
        errors++;
        $display("o_ack dropped at %0t ns while i_req was still held high", $time);
      end
      check_outputs();
    end
    i_req  = 1'b0;
    cycles = 0;
    do begin
      @(posedge i_clk);
      #1;
      cycles++;
    end while (o_ack !== 1'b0 && cycles < ACK_TIMEOUT);
    if (o_ack !== 1'b0)
      abort_on_timeout("o_ack never fell after i_req was dropped");
  endtask

  task automatic finish_test(input string name);
    $display("%-14s done, %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  task automatic after_reset();
    exp_alu  = '0;
    exp_npc  = '0;
    exp_gpr  = '0;
    exp_csr  = '0;
    exp_halt = 1'b0;
    check_value("o_ack", xword_t'(o_ack), '0);
    check_outputs();
    set_idle_inputs();
    i_rs1 = 64'd20;
    i_rs2 = 64'd22;
    run_request(0);
    finish_test("after_reset");
  endtask

  task automatic random_alu_ops();
    alu_op_t ops[12] = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_AND,
                         ALU_OR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_MUL, ALU_COPY};
    foreach (ops[i])
      for (int w = 0; w < 2; w++)
        for (int s = 0; s < 3; s++)
          repeat (2) begin
            set_idle_inputs();
            i_alu_op = ops[i];
            i_word   = w[0];
            i_b_src  = bsrc_t'(s);
            i_rs1    = rand64();
            i_rs2    = rand64();
            i_imm    = rand64();
            run_request(0);
          end
    finish_test("alu_ops");
  endtask

  task automatic divider_ops();
    alu_op_t ops[4] = '{ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    int      shift;
    foreach (ops[i])
      for (int w = 0; w < 2; w++)
        for (int n = 0; n < 6; n++) begin
          set_idle_inputs();
          i_alu_op = ops[i];
          i_word   = w[0];
          shift    = $unsigned($random(seed)) % 64;
          i_rs1    = rand64();
          i_rs2    = rand64() >> shift;
          // last two are the zero divisor and overflow cases
          if (n == 4)
            i_rs2 = '0;
          if (n == 5) begin
            i_rs1 = w[0] ? 64'h0000_0000_8000_0000 : 64'h8000_0000_0000_0000;
            i_rs2 = '1;
          end
          run_request(0);
        end
    finish_test("divider_ops");
  endtask

  task automatic branch_targets();
    branch_t kinds[7] = '{BR_NONE, BR_JAL, BR_JALR, BR_EQ, BR_NE, BR_LT, BR_GE};
    // equal, less and greater when signed and reversed when unsigned
    xword_t  lhs[3]   = '{64'd77, -64'sd5, 64'd3};
    xword_t  rhs[3]   = '{64'd77, 64'd3, -64'sd5};
    foreach (kinds[k])
      foreach (lhs[p])
        for (int u = 0; u < 2; u++) begin
          set_idle_inputs();
          i_branch = kinds[k];
          i_alu_op = u[0] ? ALU_SLTU : ALU_SLT;
          i_rs1    = lhs[p];
          i_rs2    = rhs[p];
          i_pc     = 64'h8000_0400;
          i_imm    = 64'hffff_ffff_ffff_ff80;
          run_request(0);
        end
    finish_test("branches");
  endtask

  task automatic writeback_select();
    xword_t data[2] = '{64'hfedc_ba98_8765_c3a1, 64'h0123_4567_0765_4321};
    foreach (data[d])
      for (int m = 0; m < 7; m++) begin
        set_idle_inputs();
        i_mem_to_reg = 1'b1;
        i_mem_op     = mem_op_t'(m);
        i_rdata      = data[d];
        run_request(0);
      end
    set_idle_inputs();
    i_sel_csr = 1'b1;
    i_rs1     = rand64();
    i_rs2     = rand64();
    run_request(0);
    for (int p = 0; p < 2; p++) begin
      set_idle_inputs();
      i_ex_ctr = EX_CSR_WRITE;
      i_a_pc   = p[0];
      i_rs1    = rand64();
      i_pc     = 64'h2000;
      run_request(0);
    end
    set_idle_inputs();
    i_ex_ctr = EX_EBREAK;
    run_request(0);
    finish_test("writeback");
  endtask

  task automatic held_request();
    set_idle_inputs();
    i_alu_op = ALU_XOR;
    i_rs1    = rand64();
    i_rs2    = rand64();
    run_request(5);
    set_idle_inputs();
    i_alu_op = ALU_REMU;
    i_rs1    = rand64();
    i_rs2    = 64'd1000;
    run_request(3);
    set_idle_inputs();
    i_alu_op = ALU_SUB;
    i_rs1    = rand64();
    i_rs2    = rand64();
    run_request(0);
    finish_test("backpressure");
  endtask

  initial begin
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    set_idle_inputs();
    i_rst_n = 1'b0;
    repeat (5) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;
    after_reset();
    random_alu_ops();
    divider_ops();
    branch_targets();
    writeback_select();
    held_request();
    // handshake property failures count as errors too
    errors += exu_top_i.props_i.fail_count;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// File: list.f
design/exu_pkg.sv
design/exu_div_if.sv
design/exu_alu.sv
design/exu_divider.sv
design/exu_branch_wb.sv
design/exu_top.sv
tests/exu_properties.sv
tests/exu_tb.sv

// File: Makefile
# Verilator build and run for the execute stage

VERILATOR ?= verilator
TOP       ?= exu_tb
BUILD_DIR ?= obj_dir
FILE_LIST ?= list.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

PASS_MSG := All checks passed
SRCS     := $(shell grep -v '^+' $(FILE_LIST))
BIN      := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# fails unless the pass message shows up on a line of its own
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
